// File: design/category_matcher.sv
`default_nettype none

module category_matcher #(
  parameter int                    NUM_STREAMS = 64,
  parameter scanner_pkg::keyword_t KEYWORD     = scanner_pkg::KW_USER
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              enable,
  char_stream_if.sink            pkt,
  output scanner_pkg::hit_count_t count,
  output logic                   fired
);
  import scanner_pkg::*;

  // Saved DFA state per stream
  dfa_state_t state_mem [NUM_STREAMS];

  // Restore stage, one cycle after load_state
  dfa_state_t restore_state;
  logic       restore_vld;

  // DFA outputs, registered for timing
  dfa_state_t state_out_r;
  logic       accept_r;

  // Packet contained a hit so far
  logic       match_flag;

  dfa_if dfa ();

  // Restore path
  // New stream starts from zero, else pick up the saved state
  always_ff @(posedge clk)
  begin
    if (pkt.load_state)
    begin
      if (pkt.new_stream)
        restore_state <= '0;
      else
        restore_state <= state_mem[pkt.stream_id];
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      restore_vld <= 1'b0;
    else
      restore_vld <= pkt.load_state;
  end

  // DFA inputs
  // Bytes and the restored state both go through one register
  always_ff @(posedge clk)
  begin
    dfa.ch       <= pkt.ch;
    dfa.state_in <= restore_state;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      dfa.ch_vld       <= 1'b0;
      dfa.state_in_vld <= 1'b0;
    end
    else
    begin
      dfa.ch_vld       <= pkt.ch_vld;
      dfa.state_in_vld <= restore_vld;
    end
  end

  keyword_dfa #(
    .KEYWORD (KEYWORD)
  ) dfa_i (
    .clk   (clk),
    .rst_n (rst_n),
    .dfa   (dfa.core)
  );

  // DFA outputs
  always_ff @(posedge clk)
  begin
    state_out_r <= dfa.state_out;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      accept_r <= 1'b0;
    else
      accept_r <= dfa.accept;
  end

  // Match flag and hit count
  // Flag is speculative until eop decides whether it counts
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      match_flag <= 1'b0;
      count      <= '0;
    end
    else
    begin
      // New packet starts clean
      if (pkt.load_state)
        match_flag <= 1'b0;
      if (accept_r)
        match_flag <= 1'b1;
      if (pkt.eop)
      begin
        if (enable)
          count <= count + hit_count_t'(match_flag);
        else
          // Disabled category drops the hit
          match_flag <= 1'b0;
      end
    end
  end

  // Save DFA state for the next packet of this stream
  // Disabled category keeps the previously saved state
  always_ff @(posedge clk)
  begin
    if (pkt.eop && enable)
      state_mem[pkt.stream_id] <= state_out_r;
  end

  // Registered accept shortens the path from keyword to fired
  assign fired = match_flag | accept_r;

  // Tracker spacing keeps restore and bytes apart
  a_no_byte_on_load: assert property (@(posedge clk) disable iff (!rst_n)
    !(pkt.ch_vld && pkt.load_state));

  // Count only holds or steps by one
  a_count_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> (count == $past(count)) ||
                     (count == hit_count_t'($past(count) + 1'b1)));

endmodule

`default_nettype wire

// File: design/char_stream_if.sv
`default_nettype none

interface char_stream_if;
  import scanner_pkg::*;

  // Start of packet, restore DFA state this cycle
  logic       load_state;
  // Stream id not seen before, only valid with load_state
  logic       new_stream;
  // Held from load_state until the next packet
  stream_id_t stream_id;
  // Payload byte and its strobe
  byte_t      ch;
  logic       ch_vld;
  // End of packet strobe
  logic       eop;

  // Stream tracker side
  modport source (
    output load_state, new_stream, stream_id, ch, ch_vld, eop
  );

  // Category matcher side
  modport sink (
    input load_state, new_stream, stream_id, ch, ch_vld, eop
  );

endinterface

`default_nettype wire

// File: design/dfa_if.sv
`default_nettype none

interface dfa_if;
  import scanner_pkg::*;

  // State overwrite from the matcher
  dfa_state_t state_in;
  logic       state_in_vld;
  // Byte to step the automaton with
  byte_t      ch;
  logic       ch_vld;
  // Current state, saved by the matcher at end of packet
  dfa_state_t state_out;
  // Keyword completed on this byte
  logic       accept;

  // Matcher side
  modport ctrl (
    output state_in, state_in_vld, ch, ch_vld,
    input  state_out, accept
  );

  // Automaton side
  modport core (
    input  state_in, state_in_vld, ch, ch_vld,
    output state_out, accept
  );

endinterface

`default_nettype wire

// File: design/keyword_dfa.sv
`default_nettype none

module keyword_dfa #(
  parameter scanner_pkg::keyword_t KEYWORD = scanner_pkg::KW_USER
) (
  input  wire logic clk,
  input  wire logic rst_n,
  dfa_if.core       dfa
);
  import scanner_pkg::*;

  // Last position before the keyword completes
  localparam dfa_state_t LAST_STATE = dfa_state_t'(KEYWORD_LEN - 1);

  // Bytes matched so far
  dfa_state_t state;
  dfa_state_t next_state;

  // Byte idx of the keyword, idx 0 is the first character
  function automatic byte_t kw_byte(input int idx);
    return KEYWORD[8*(KEYWORD_LEN-1-idx) +: 8];
  endfunction

  // Step on a valid byte
  // Mismatch falls back to 1 if the byte restarts the keyword
  // Exact only for keywords without a repeated prefix
  always_comb
  begin
    next_state = state;
    dfa.accept = 1'b0;
    if (dfa.ch_vld)
    begin
      if (dfa.ch == kw_byte(int'(state)))
      begin
        if (state == LAST_STATE)
        begin
          // Whole keyword seen, start over
          next_state = '0;
          dfa.accept = 1'b1;
        end
        else
        begin
          next_state = dfa_state_t'(state + 1'b1);
        end
      end
      else if (dfa.ch == kw_byte(0))
      begin
        next_state = dfa_state_t'(1);
      end
      else
      begin
        next_state = '0;
      end
    end
  end

  // Load from the matcher takes priority over a byte step
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= '0;
    else if (dfa.state_in_vld)
      state <= dfa.state_in;
    else
      state <= next_state;
  end

  assign dfa.state_out = state;

  // Restored state comes from this same counter, so it stays in range
  a_state_range: assert property (@(posedge clk) disable iff (!rst_n)
    dfa.state_out <= LAST_STATE);

endmodule

`default_nettype wire

// File: design/pkt_scanner_top.sv
`default_nettype none

module pkt_scanner_top #(
  parameter int NUM_STREAMS = 64
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    sop,
  input  wire logic                    eop,
  input  wire scanner_pkg::stream_id_t stream_id,
  input  wire scanner_pkg::byte_t      char_in,
  input  wire logic                    char_vld,
  input  wire logic                    enable_user,
  input  wire logic                    enable_pass,
  output scanner_pkg::hit_count_t      count_user,
  output scanner_pkg::hit_count_t      count_pass,
  output logic                         fired_user,
  output logic                         fired_pass
);
  import scanner_pkg::*;

  // Category slots
  localparam int USER_IDX = 0;
  localparam int PASS_IDX = 1;

  logic [NUM_CATEGORIES-1:0] cat_enable;
  logic [NUM_CATEGORIES-1:0] cat_fired;

  // Aligned byte stream shared by both matchers
  char_stream_if pkt ();

  assign cat_enable[USER_IDX] = enable_user;
  assign cat_enable[PASS_IDX] = enable_pass;
  assign fired_user = cat_fired[USER_IDX];
  assign fired_pass = cat_fired[PASS_IDX];

  stream_tracker #(
    .NUM_STREAMS (NUM_STREAMS)
  ) tracker (
    .clk       (clk),
    .rst_n     (rst_n),
    .sop       (sop),
    .eop       (eop),
    .stream_id (stream_id),
    .ch        (char_in),
    .ch_vld    (char_vld),
    .pkt       (pkt.source)
  );

  category_matcher #(
    .NUM_STREAMS (NUM_STREAMS),
    .KEYWORD     (KW_USER)
  ) user_matcher (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (cat_enable[USER_IDX]),
    .pkt    (pkt.sink),
    .count  (count_user),
    .fired  (cat_fired[USER_IDX])
  );

  category_matcher #(
    .NUM_STREAMS (NUM_STREAMS),
    .KEYWORD     (KW_PASS)
  ) pass_matcher (
    .clk    (clk),
    .rst_n  (rst_n),
    .enable (cat_enable[PASS_IDX]),
    .pkt    (pkt.sink),
    .count  (count_pass),
    .fired  (cat_fired[PASS_IDX])
  );

endmodule

`default_nettype wire

// File: design/scanner_pkg.sv
`default_nettype none

package scanner_pkg;

  // One payload character
  typedef logic [7:0] byte_t;

  // Stream identifier carried with every packet
  typedef logic [5:0] stream_id_t;

  // DFA state word
  // Same width as the full regex engine it replaces
  // Only the low values are used here, bytes of keyword matched so far
  typedef logic [10:0] dfa_state_t;

  // Per-category count of packets that contained a hit
  typedef logic [15:0] hit_count_t;

  // Every keyword is this many bytes long
  localparam int KEYWORD_LEN = 4;

  // Keyword word type
  // First character sits in the top byte
  typedef logic [8*KEYWORD_LEN-1:0] keyword_t;

  // Login name command
  localparam keyword_t KW_USER = "USER";

  // Password command
  localparam keyword_t KW_PASS = "PASS";

  // One matcher per keyword
  localparam int NUM_CATEGORIES = 2;

endpackage

`default_nettype wire

// File: design/stream_tracker.sv
`default_nettype none

module stream_tracker #(
  parameter int NUM_STREAMS = 64
) (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   sop,
  input  wire logic                   eop,
  input  wire scanner_pkg::stream_id_t stream_id,
  input  wire scanner_pkg::byte_t      ch,
  input  wire logic                   ch_vld,
  char_stream_if.source               pkt
);
  import scanner_pkg::*;

  // One bit per stream id, set once a packet of it arrived
  logic [NUM_STREAMS-1:0] seen;

  // Seen table and stream id hold
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      seen           <= '0;
      pkt.new_stream <= 1'b0;
    end
    else if (sop)
    begin
      pkt.new_stream  <= !seen[stream_id];
      seen[stream_id] <= 1'b1;
    end
  end

  // Id stays put until the next sop
  always_ff @(posedge clk)
  begin
    if (sop)
      pkt.stream_id <= stream_id;
  end

  // Payload byte delayed to line up with load_state
  always_ff @(posedge clk)
  begin
    pkt.ch <= ch;
  end

  // Strobes
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      pkt.load_state <= 1'b0;
      pkt.ch_vld     <= 1'b0;
      pkt.eop        <= 1'b0;
    end
    else
    begin
      pkt.load_state <= sop;
      pkt.ch_vld     <= ch_vld;
      pkt.eop        <= eop;
    end
  end

  // Packet framing from the source
  a_sop_no_byte: assert property (@(posedge clk) disable iff (!rst_n)
    !(sop && ch_vld));

  a_sop_no_eop: assert property (@(posedge clk) disable iff (!rst_n)
    !(sop && eop));

endmodule

`default_nettype wire

// File: sim/tb_pkt_scanner.sv
`default_nettype none

module tb_pkt_scanner;
  timeunit 1ns;
  timeprecision 1ps;
  import scanner_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_IDS      = 64;
  localparam int RAND_PACKETS = 200;
  localparam int RAND_STREAMS = 8;
  // Random payload is built from up to this many pieces of at most 4 bytes
  localparam int MAX_PIECES   = 8;
  // Framing cycles plus a gap before every byte in the worst case
  localparam int MAX_PKT_CYCLES = 6 + 2 * KEYWORD_LEN * MAX_PIECES;
  localparam int MAX_PACKETS  = RAND_PACKETS + 20;
  localparam int WATCHDOG_NS  = (RESET_CYCLES + MAX_PACKETS * MAX_PKT_CYCLES) * CLK_PERIOD * 2;

  logic       clk;
  logic       rst_n;
  logic       sop;
  logic       eop;
  stream_id_t stream_id;
  byte_t      char_in;
  logic       char_vld;
  logic       enable_user;
  logic       enable_pass;
  hit_count_t count_user;
  hit_count_t count_pass;
  logic       fired_user;
  logic       fired_pass;

  // Reference model with USER at index 0 and PASS at index 1
  int         saved [2][NUM_IDS];
  int         live [2];
  logic       hit [2];
  logic       en [2];
  logic       seen_tb [NUM_IDS];
  hit_count_t exp_count [2];
  // Keyword completed by the byte driven this cycle
  logic       done [2];
  logic       any_kw;
  byte_t      payload [$];

  pkt_scanner_top #(
    .NUM_STREAMS (NUM_IDS)
  ) dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .sop         (sop),
    .eop         (eop),
    .stream_id   (stream_id),
    .char_in     (char_in),
    .char_vld    (char_vld),
    .enable_user (enable_user),
    .enable_pass (enable_pass),
    .count_user  (count_user),
    .count_pass  (count_pass),
    .fired_user  (fired_user),
    .fired_pass  (fired_pass)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_on_failure(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first failure");
  endtask

  // Move to the drive point of the next cycle
  // Strobes default low
  task automatic next_cycle();
    @(posedge clk);
    #5;
    sop      = 1'b0;
    eop      = 1'b0;
    char_vld = 1'b0;
    done[0]  = 1'b0;
    done[1]  = 1'b0;
  endtask

  function automatic byte_t kw_char(input int cat, input int idx);
    string kw;
    kw = (cat == 0) ? "USER" : "PASS";
    return kw.getc(idx);
  endfunction

  task automatic push_text(input string s);
    for (int i = 0; i < s.len(); i++)
      payload.push_back(s.getc(i));
  endtask

  // Keyword progress per category
  // A mismatch restarts at 1 when the byte is the keyword's first letter
  task automatic model_byte(input byte_t b);
    int c;
    int p;
    for (c = 0; c < 2; c++)
    begin
      p = live[c];
      if (b == kw_char(c, p))
        p = p + 1;
      else if (b == kw_char(c, 0))
        p = 1;
      else
        p = 0;
      if (p == KEYWORD_LEN)
      begin
        hit[c]  = 1'b1;
        done[c] = 1'b1;
        any_kw  = 1'b1;
        p       = 0;
      end
      live[c] = p;
    end
  endtask

  // One packet with the minimum protocol spacing
  // Optional idle cycles between bytes
  task automatic send_packet(input int id, input logic en_u, input logic en_p,
                             input logic with_gaps);
    int c;
    next_cycle();
    sop         = 1'b1;
    stream_id   = stream_id_t'(id);
    enable_user = en_u;
    enable_pass = en_p;
    en[0]       = en_u;
    en[1]       = en_p;
    // Never-seen stream starts from zero progress
    for (c = 0; c < 2; c++)
    begin
      live[c] = seen_tb[id] ? saved[c][id] : 0;
      hit[c]  = 1'b0;
    end
    seen_tb[id] = 1'b1;
    repeat (2) next_cycle();
    foreach (payload[i])
    begin
      if (with_gaps && $urandom_range(3) == 0)
        next_cycle();
      next_cycle();
      char_vld = 1'b1;
      char_in  = payload[i];
      model_byte(payload[i]);
    end
    repeat (3) next_cycle();
    eop = 1'b1;
    // Enabled categories count the hit and keep the progress for this stream
    for (c = 0; c < 2; c++)
    begin
      if (en[c])
      begin
        exp_count[c] = exp_count[c] + hit_count_t'(hit[c]);
        saved[c][id] = live[c];
      end
    end
    next_cycle();
    payload.delete();
  endtask

  // Mix of whole keywords, keyword letters and arbitrary bytes
  task automatic build_random_payload();
    string letters;
    int    r;
    letters = "USERPA";
    repeat ($urandom_range(MAX_PIECES, 1))
    begin
      r = $urandom_range(7);
      if (r == 0)
        push_text("USER");
      else if (r == 1)
        push_text("PASS");
      else if (r < 6)
        payload.push_back(letters.getc($urandom_range(5)));
      else
        payload.push_back(byte_t'($urandom_range(255)));
    end
  endtask

  // Counts settle 2 cycles after eop
  count_after_eop: assert property (@(posedge clk) disable iff (!rst_n)
    eop |-> ##2 (count_user == exp_count[0] && count_pass == exp_count[1]))
    else stop_on_failure($sformatf("mismatch at %0d ns: counts %0d %0d, expected %0d %0d",
      $time, $sampled(count_user), $sampled(count_pass), exp_count[0], exp_count[1]));

  idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !any_kw |-> (count_user == '0 && count_pass == '0 && !fired_user && !fired_pass))
    else stop_on_failure($sformatf("mismatch at %0d ns: outputs active before any keyword",
      $time));

  fired_user_rise: assert property (@(posedge clk) disable iff (!rst_n)
    done[0] |-> ##[1:3] fired_user)
    else stop_on_failure($sformatf("mismatch at %0d ns: fired_user missed a USER", $time));

  fired_pass_rise: assert property (@(posedge clk) disable iff (!rst_n)
    done[1] |-> ##[1:3] fired_pass)
    else stop_on_failure($sformatf("mismatch at %0d ns: fired_pass missed a PASS", $time));

  // New packet clears both flags
  fired_clear_sop: assert property (@(posedge clk) disable iff (!rst_n)
    sop |-> ##2 (!fired_user && !fired_pass))
    else stop_on_failure($sformatf("mismatch at %0d ns: fired still high after sop", $time));

  fired_user_off: assert property (@(posedge clk) disable iff (!rst_n)
    (eop && !enable_user) |-> ##2 !fired_user)
    else stop_on_failure($sformatf("mismatch at %0d ns: disabled fired_user high", $time));

  fired_pass_off: assert property (@(posedge clk) disable iff (!rst_n)
    (eop && !enable_pass) |-> ##2 !fired_pass)
    else stop_on_failure($sformatf("mismatch at %0d ns: disabled fired_pass high", $time));

  initial
  begin
    #(WATCHDOG_NS);
    stop_on_failure("timeout: the packet sequence did not complete in time");
  end

  initial
  begin
    int id;
    void'($urandom(32'h2119_7042));
    clk         = 1'b0;
    rst_n       = 1'b0;
    sop         = 1'b0;
    eop         = 1'b0;
    stream_id   = '0;
    char_in     = '0;
    char_vld    = 1'b0;
    enable_user = 1'b1;
    enable_pass = 1'b1;
    any_kw      = 1'b0;
    done[0]     = 1'b0;
    done[1]     = 1'b0;
    exp_count[0] = '0;
    exp_count[1] = '0;
    foreach (seen_tb[i])
      seen_tb[i] = 1'b0;
    foreach (saved[c, i])
      saved[c][i] = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // No keyword yet
    push_text("HELLO");
    send_packet(0, 1'b1, 1'b1, 1'b0);
    // Single keyword on new streams
    push_text("xxUSERyy");
    send_packet(10, 1'b1, 1'b1, 1'b0);
    push_text("PASSword");
    send_packet(11, 1'b1, 1'b1, 1'b0);
    // Split across two packets of one stream
    push_text("ABUS");
    send_packet(12, 1'b1, 1'b1, 1'b0);
    push_text("ERCD");
    send_packet(12, 1'b1, 1'b1, 1'b0);
    // Split halves interleaved with another stream
    push_text("ZUS");
    send_packet(13, 1'b1, 1'b1, 1'b0);
    push_text("PA");
    send_packet(14, 1'b1, 1'b1, 1'b0);
    push_text("ER");
    send_packet(13, 1'b1, 1'b1, 1'b0);
    push_text("SS");
    send_packet(14, 1'b1, 1'b1, 1'b0);
    // Second half lands on a never-seen stream
    push_text("QUS");
    send_packet(15, 1'b1, 1'b1, 1'b0);
    push_text("ER");
    send_packet(16, 1'b1, 1'b1, 1'b0);
    // Disabled categories on seen streams
    push_text("USER");
    send_packet(10, 1'b0, 1'b1, 1'b0);
    push_text("aPASS");
    send_packet(11, 1'b1, 1'b0, 1'b0);

    for (int n = 0; n < RAND_PACKETS; n++)
    begin
      id = $urandom_range(RAND_STREAMS - 1);
      build_random_payload();
      // First packet of a stream runs with both categories on so each matcher saves a state
      if (!seen_tb[id])
        send_packet(id, 1'b1, 1'b1, 1'b1);
      else
        send_packet(id, $urandom_range(3) != 0, $urandom_range(3) != 0, 1'b1);
    end

    repeat (4) next_cycle();
    if (count_user == exp_count[0] && count_pass == exp_count[1])
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
    else
    begin
      stop_on_failure($sformatf("mismatch at %0d ns: final counts %0d %0d, expected %0d %0d",
        $time, count_user, count_pass, exp_count[0], exp_count[1]));
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
design/scanner_pkg.sv
design/char_stream_if.sv
design/dfa_if.sv
design/keyword_dfa.sv
design/category_matcher.sv
design/stream_tracker.sv
design/pkt_scanner_top.sv
sim/tb_pkt_scanner.sv
